/* hw/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    localparam int DATA_W   = 32;
    localparam int TAG_W    = 5;
    localparam int OPCODE_W = 4;
    localparam int SHAMT_W  = 5;

    // Entries per reservation station
    localparam int RS_DEPTH = 4;
    localparam int RS_IDX_W = $clog2(RS_DEPTH);

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [RS_IDX_W-1:0] rs_idx_t;
    typedef logic [RS_IDX_W-1:0] rs_age_t;

    // The top opcode bit selects the unit class
    typedef enum opcode_t {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_SLT = 4'h2,
        OP_AND = 4'h8,
        OP_OR  = 4'h9,
        OP_XOR = 4'hA,
        OP_SLL = 4'hB,
        OP_SRL = 4'hC
    } op_e;

    typedef enum logic {
        FU_ARITH = 1'b0,
        FU_LOGIC = 1'b1
    } fu_class_e;

endpackage

`default_nettype wire

/* hw/issue_if.sv */
`default_nettype none
`timescale 1ns/100ps

// One issued instruction travelling from a station to its unit
interface issue_if
    import issue_pkg::*;
();

    logic    valid;
    logic    stall;
    opcode_t opcode;
    data_t   src_a;
    data_t   src_b;
    tag_t    tag;

    modport station (output valid, output opcode, output src_a, output src_b, output tag,
                     input stall);

    modport unit (input valid, input opcode, input src_a, input src_b, input tag,
                  output stall);

endinterface

`default_nettype wire

/* hw/reservation_station.sv */
`default_nettype none
`timescale 1ns/100ps

module reservation_station
    import issue_pkg::*;
#(
    parameter fu_class_e FU_CLASS = FU_ARITH
) (
    input  logic    clk,
    input  logic    i_rst,
    input  logic    i_flush,

    input  logic    i_dispatch_valid,
    input  opcode_t i_dispatch_opcode,
    input  tag_t    i_dispatch_src_tag_a,
    input  tag_t    i_dispatch_src_tag_b,
    input  data_t   i_dispatch_src_data_a,
    input  data_t   i_dispatch_src_data_b,
    input  logic    i_dispatch_src_rdy_a,
    input  logic    i_dispatch_src_rdy_b,
    input  tag_t    i_dispatch_dst_tag,
    output logic    o_stall,

    input  logic    i_cdb_valid,
    input  tag_t    i_cdb_tag,
    input  data_t   i_cdb_data,

    issue_if.station issue
);

    logic [RS_DEPTH-1:0] entry_valid;
    logic [RS_DEPTH-1:0] entry_rdy_a;
    logic [RS_DEPTH-1:0] entry_rdy_b;
    logic [RS_DEPTH-1:0] entry_ready;
    opcode_t             entry_opcode [RS_DEPTH];
    tag_t                entry_dst_tag [RS_DEPTH];
    tag_t                entry_tag_a [RS_DEPTH];
    tag_t                entry_tag_b [RS_DEPTH];
    data_t               entry_data_a [RS_DEPTH];
    data_t               entry_data_b [RS_DEPTH];
    rs_age_t             entry_age [RS_DEPTH];
    rs_age_t             age_next [RS_DEPTH];

    logic [RS_DEPTH-1:0] alloc_sel;
    logic [RS_DEPTH-1:0] write_sel;
    logic [RS_DEPTH-1:0] issue_sel;
    rs_idx_t             issue_idx;
    logic                issuing;
    logic                class_match;
    logic                dispatch_en;
    logic                disp_hit_a;
    logic                disp_hit_b;

    assign class_match = (fu_class_e'(i_dispatch_opcode[OPCODE_W-1]) == FU_CLASS);
    assign o_stall     = &entry_valid;
    assign dispatch_en = i_dispatch_valid && class_match && !o_stall;

    // A source may be broadcast on the CDB in the very cycle it is dispatched
    assign disp_hit_a = i_cdb_valid && (i_cdb_tag == i_dispatch_src_tag_a);
    assign disp_hit_b = i_cdb_valid && (i_cdb_tag == i_dispatch_src_tag_b);

    // Lowest-numbered empty entry takes the new instruction
    always_comb begin
        logic found;
        found     = 1'b0;
        alloc_sel = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!entry_valid[i] && !found) begin
                alloc_sel[i] = 1'b1;
                found        = 1'b1;
            end
        end
    end

    assign write_sel   = alloc_sel & {RS_DEPTH{dispatch_en}};
    assign entry_ready = entry_valid & entry_rdy_a & entry_rdy_b;

    // Age matrix. An entry wins when it is older than every other ready entry
    always_comb begin
        logic [RS_DEPTH-1:0] beats;
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int j = 0; j < RS_DEPTH; j++) begin
                beats[j] = (i == j) || !entry_ready[j] || (entry_age[i] > entry_age[j]);
            end
            issue_sel[i] = entry_ready[i] && (&beats) && !issue.stall;
        end
    end

    always_comb begin
        issue_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (issue_sel[i]) begin
                issue_idx = rs_idx_t'(i);
            end
        end
    end

    assign issuing = |issue_sel;

    // Younger entries grow older on dispatch; entries older than the issued one close the gap
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            age_next[i] = entry_age[i];
            if (dispatch_en) begin
                age_next[i] = age_next[i] + 1'b1;
            end
            if (issuing && (entry_age[i] > entry_age[issue_idx])) begin
                age_next[i] = age_next[i] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (i_rst || i_flush) begin
                entry_valid[i] <= 1'b0;
            end else if (write_sel[i]) begin
                entry_valid[i] <= 1'b1;
            end else if (issue_sel[i]) begin
                entry_valid[i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (write_sel[i]) begin
                entry_opcode[i]  <= i_dispatch_opcode;
                entry_dst_tag[i] <= i_dispatch_dst_tag;
                entry_tag_a[i]   <= i_dispatch_src_tag_a;
                entry_tag_b[i]   <= i_dispatch_src_tag_b;
                entry_rdy_a[i]   <= i_dispatch_src_rdy_a || disp_hit_a;
                entry_rdy_b[i]   <= i_dispatch_src_rdy_b || disp_hit_b;
                entry_data_a[i]  <= i_dispatch_src_rdy_a ? i_dispatch_src_data_a : i_cdb_data;
                entry_data_b[i]  <= i_dispatch_src_rdy_b ? i_dispatch_src_data_b : i_cdb_data;
                entry_age[i]     <= '0;
            end else begin
                entry_age[i] <= age_next[i];
                // Wakeup: capture the broadcast data for a waiting source
                if (!entry_rdy_a[i] && i_cdb_valid && (i_cdb_tag == entry_tag_a[i])) begin
                    entry_rdy_a[i]  <= 1'b1;
                    entry_data_a[i] <= i_cdb_data;
                end
                if (!entry_rdy_b[i] && i_cdb_valid && (i_cdb_tag == entry_tag_b[i])) begin
                    entry_rdy_b[i]  <= 1'b1;
                    entry_data_b[i] <= i_cdb_data;
                end
            end
        end
    end

    // Issue register holds its contents while the unit stalls
    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            issue.valid <= 1'b0;
        end else if (!issue.stall) begin
            issue.valid <= issuing;
        end
    end

    always_ff @(posedge clk) begin
        if (!issue.stall) begin
            issue.opcode <= entry_opcode[issue_idx];
            issue.src_a  <= entry_data_a[issue_idx];
            issue.src_b  <= entry_data_b[issue_idx];
            issue.tag    <= entry_dst_tag[issue_idx];
        end
    end

    a_issue_onehot: assert property (@(posedge clk) disable iff (i_rst)
        $onehot0(issue_sel))
        else $error("more than one entry selected for issue");

    a_no_dispatch_when_full: assert property (@(posedge clk) disable iff (i_rst)
        (i_dispatch_valid && class_match) |-> !o_stall)
        else $error("dispatch presented to a full station");

endmodule

`default_nettype wire

/* hw/arith_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module arith_unit
    import issue_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst,
    input  logic  i_flush,
    issue_if.unit issue,
    input  logic  i_stall,
    output logic  o_result_valid,
    output tag_t  o_result_tag,
    output data_t o_result_data
);

    data_t result;

    // A held result blocks the station from issuing
    assign issue.stall = o_result_valid && i_stall;

    always_comb begin
        case (issue.opcode)
            OP_ADD:  result = issue.src_a + issue.src_b;
            OP_SUB:  result = issue.src_a - issue.src_b;
            OP_SLT:  result = data_t'($signed(issue.src_a) < $signed(issue.src_b));
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_result_valid <= 1'b0;
        end else if (!issue.stall) begin
            o_result_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!issue.stall) begin
            o_result_tag  <= issue.tag;
            o_result_data <= result;
        end
    end

    a_arith_class: assert property (@(posedge clk) disable iff (i_rst)
        issue.valid |-> (fu_class_e'(issue.opcode[OPCODE_W-1]) == FU_ARITH))
        else $error("logic opcode issued to the arithmetic unit");

endmodule

`default_nettype wire

/* hw/logic_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module logic_unit
    import issue_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst,
    input  logic  i_flush,
    issue_if.unit issue,
    input  logic  i_stall,
    output logic  o_result_valid,
    output tag_t  o_result_tag,
    output data_t o_result_data
);

    data_t result;

    assign issue.stall = o_result_valid && i_stall;

    // Shift amount comes from the low bits of operand B
    always_comb begin
        case (issue.opcode)
            OP_AND:  result = issue.src_a & issue.src_b;
            OP_OR:   result = issue.src_a | issue.src_b;
            OP_XOR:  result = issue.src_a ^ issue.src_b;
            OP_SLL:  result = issue.src_a << issue.src_b[SHAMT_W-1:0];
            OP_SRL:  result = issue.src_a >> issue.src_b[SHAMT_W-1:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_result_valid <= 1'b0;
        end else if (!issue.stall) begin
            o_result_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!issue.stall) begin
            o_result_tag  <= issue.tag;
            o_result_data <= result;
        end
    end

    a_logic_class: assert property (@(posedge clk) disable iff (i_rst)
        issue.valid |-> (fu_class_e'(issue.opcode[OPCODE_W-1]) == FU_LOGIC))
        else $error("arithmetic opcode issued to the logic unit");

endmodule

`default_nettype wire

/* hw/cdb_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

module cdb_arbiter
    import issue_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst,
    input  logic  i_flush,

    input  logic  i_arith_valid,
    input  tag_t  i_arith_tag,
    input  data_t i_arith_data,
    input  logic  i_logic_valid,
    input  tag_t  i_logic_tag,
    input  data_t i_logic_data,

    output logic  o_arith_stall,
    output logic  o_logic_stall,

    output logic  o_cdb_valid,
    output tag_t  o_cdb_tag,
    output data_t o_cdb_data
);

    // Unit that wins the next conflict
    fu_class_e prio;
    logic      grant_arith;
    logic      grant_logic;
    logic      conflict;

    assign conflict    = i_arith_valid && i_logic_valid;
    assign grant_arith = i_arith_valid && (!i_logic_valid || (prio == FU_ARITH));
    assign grant_logic = i_logic_valid && !grant_arith;

    assign o_arith_stall = i_arith_valid && !grant_arith;
    assign o_logic_stall = i_logic_valid && !grant_logic;

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            prio        <= FU_ARITH;
            o_cdb_valid <= 1'b0;
        end else begin
            o_cdb_valid <= grant_arith || grant_logic;
            // The loser of a conflict gets priority next time
            if (conflict) begin
                prio <= grant_arith ? FU_LOGIC : FU_ARITH;
            end
        end
    end

    always_ff @(posedge clk) begin
        o_cdb_tag  <= grant_arith ? i_arith_tag : i_logic_tag;
        o_cdb_data <= grant_arith ? i_arith_data : i_logic_data;
    end

    a_single_stall: assert property (@(posedge clk) disable iff (i_rst)
        !(o_arith_stall && o_logic_stall))
        else $error("both units stalled in one cycle");

endmodule

`default_nettype wire

/* hw/issue_top.sv */
`default_nettype none
`timescale 1ns/100ps

module issue_top
    import issue_pkg::*;
(
    input  logic    clk,
    input  logic    i_rst,
    input  logic    i_flush,

    input  logic    i_dispatch_valid,
    input  opcode_t i_dispatch_opcode,
    input  tag_t    i_dispatch_src_tag_a,
    input  tag_t    i_dispatch_src_tag_b,
    input  data_t   i_dispatch_src_data_a,
    input  data_t   i_dispatch_src_data_b,
    input  logic    i_dispatch_src_rdy_a,
    input  logic    i_dispatch_src_rdy_b,
    input  tag_t    i_dispatch_dst_tag,

    output logic    o_stall_arith,
    output logic    o_stall_logic,
    output logic    o_cdb_valid,
    output tag_t    o_cdb_tag,
    output data_t   o_cdb_data
);

    issue_if arith_issue ();
    issue_if logic_issue ();

    logic  arith_valid;
    tag_t  arith_tag;
    data_t arith_data;
    logic  arith_stall;
    logic  logic_valid;
    tag_t  logic_tag;
    data_t logic_data;
    logic  logic_stall;

    reservation_station #(.FU_CLASS(FU_ARITH)) rs_arith_i (
        .clk                   (clk),
        .i_rst                 (i_rst),
        .i_flush               (i_flush),
        .i_dispatch_valid      (i_dispatch_valid),
        .i_dispatch_opcode     (i_dispatch_opcode),
        .i_dispatch_src_tag_a  (i_dispatch_src_tag_a),
        .i_dispatch_src_tag_b  (i_dispatch_src_tag_b),
        .i_dispatch_src_data_a (i_dispatch_src_data_a),
        .i_dispatch_src_data_b (i_dispatch_src_data_b),
        .i_dispatch_src_rdy_a  (i_dispatch_src_rdy_a),
        .i_dispatch_src_rdy_b  (i_dispatch_src_rdy_b),
        .i_dispatch_dst_tag    (i_dispatch_dst_tag),
        .o_stall               (o_stall_arith),
        .i_cdb_valid           (o_cdb_valid),
        .i_cdb_tag             (o_cdb_tag),
        .i_cdb_data            (o_cdb_data),
        .issue                 (arith_issue)
    );

    reservation_station #(.FU_CLASS(FU_LOGIC)) rs_logic_i (
        .clk                   (clk),
        .i_rst                 (i_rst),
        .i_flush               (i_flush),
        .i_dispatch_valid      (i_dispatch_valid),
        .i_dispatch_opcode     (i_dispatch_opcode),
        .i_dispatch_src_tag_a  (i_dispatch_src_tag_a),
        .i_dispatch_src_tag_b  (i_dispatch_src_tag_b),
        .i_dispatch_src_data_a (i_dispatch_src_data_a),
        .i_dispatch_src_data_b (i_dispatch_src_data_b),
        .i_dispatch_src_rdy_a  (i_dispatch_src_rdy_a),
        .i_dispatch_src_rdy_b  (i_dispatch_src_rdy_b),
        .i_dispatch_dst_tag    (i_dispatch_dst_tag),
        .o_stall               (o_stall_logic),
        .i_cdb_valid           (o_cdb_valid),
        .i_cdb_tag             (o_cdb_tag),
        .i_cdb_data            (o_cdb_data),
        .issue                 (logic_issue)
    );

    arith_unit arith_unit_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_flush        (i_flush),
        .issue          (arith_issue),
        .i_stall        (arith_stall),
        .o_result_valid (arith_valid),
        .o_result_tag   (arith_tag),
        .o_result_data  (arith_data)
    );

    logic_unit logic_unit_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_flush        (i_flush),
        .issue          (logic_issue),
        .i_stall        (logic_stall),
        .o_result_valid (logic_valid),
        .o_result_tag   (logic_tag),
        .o_result_data  (logic_data)
    );

    cdb_arbiter cdb_arbiter_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_flush       (i_flush),
        .i_arith_valid (arith_valid),
        .i_arith_tag   (arith_tag),
        .i_arith_data  (arith_data),
        .i_logic_valid (logic_valid),
        .i_logic_tag   (logic_tag),
        .i_logic_data  (logic_data),
        .o_arith_stall (arith_stall),
        .o_logic_stall (logic_stall),
        .o_cdb_valid   (o_cdb_valid),
        .o_cdb_tag     (o_cdb_tag),
        .o_cdb_data    (o_cdb_data)
    );

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_clkgen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_issue.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_issue
    import issue_pkg::*;
();

    localparam int    MAX_LINES       = 64;
    localparam int    CYCLES_PER_LINE = 40;
    localparam int    RESET_CYCLES    = 5;
    localparam int    N_TAGS          = 1 << TAG_W;
    localparam int    NEVER_READY     = 32'h7fff_ffff;
    localparam string PATTERN_FILE    = "verif/issue_patterns.txt";

    // Control words of the pattern file
    localparam int CTRL_DISPATCH = 0;
    localparam int CTRL_ORDERED  = 1;
    localparam int CTRL_DRAIN    = 2;
    localparam int CTRL_FLUSH    = 3;
    localparam int CTRL_STALL    = 4;

    logic    clk;
    logic    i_rst;
    logic    i_flush;
    logic    i_dispatch_valid;
    opcode_t i_dispatch_opcode;
    tag_t    i_dispatch_src_tag_a;
    tag_t    i_dispatch_src_tag_b;
    data_t   i_dispatch_src_data_a;
    data_t   i_dispatch_src_data_b;
    logic    i_dispatch_src_rdy_a;
    logic    i_dispatch_src_rdy_b;
    tag_t    i_dispatch_dst_tag;
    logic    o_stall_arith;
    logic    o_stall_logic;
    logic    o_cdb_valid;
    tag_t    o_cdb_tag;
    data_t   o_cdb_data;

    // Expected result travels alongside the dispatch inputs
    data_t   cur_exp;

    int      n_lines;
    int      line_ctrl   [MAX_LINES];
    opcode_t line_op     [MAX_LINES];
    tag_t    line_dst    [MAX_LINES];
    tag_t    line_tag_a  [MAX_LINES];
    tag_t    line_tag_b  [MAX_LINES];
    logic    line_rdy_a  [MAX_LINES];
    logic    line_rdy_b  [MAX_LINES];
    data_t   line_data_a [MAX_LINES];
    data_t   line_data_b [MAX_LINES];
    data_t   line_exp    [MAX_LINES];

    // Scoreboard indexed by destination tag
    logic      pending    [N_TAGS];
    data_t     exp_data   [N_TAGS];
    fu_class_e tag_class  [N_TAGS];
    int        disp_seq   [N_TAGS];
    int        ready_at   [N_TAGS];
    logic      wait_a     [N_TAGS];
    logic      wait_b     [N_TAGS];
    tag_t      wait_tag_a [N_TAGS];
    tag_t      wait_tag_b [N_TAGS];
    int        owed         = 0;
    int        owed_q       = 0;
    int        n_dispatched = 0;
    int        edge_count   = 0;
    logic      after_clear  = 1'b0;
    int        cycle_count  = 0;
    int        cycle_limit  = 0;

    tb_clkgen #(.PERIOD_NS(4.0)) clkgen_i (
        .o_clk (clk)
    );

    issue_top issue_top_i (
        .clk                   (clk),
        .i_rst                 (i_rst),
        .i_flush               (i_flush),
        .i_dispatch_valid      (i_dispatch_valid),
        .i_dispatch_opcode     (i_dispatch_opcode),
        .i_dispatch_src_tag_a  (i_dispatch_src_tag_a),
        .i_dispatch_src_tag_b  (i_dispatch_src_tag_b),
        .i_dispatch_src_data_a (i_dispatch_src_data_a),
        .i_dispatch_src_data_b (i_dispatch_src_data_b),
        .i_dispatch_src_rdy_a  (i_dispatch_src_rdy_a),
        .i_dispatch_src_rdy_b  (i_dispatch_src_rdy_b),
        .i_dispatch_dst_tag    (i_dispatch_dst_tag),
        .o_stall_arith         (o_stall_arith),
        .o_stall_logic         (o_stall_logic),
        .o_cdb_valid           (o_cdb_valid),
        .o_cdb_tag             (o_cdb_tag),
        .o_cdb_data            (o_cdb_data)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s expected %h got %h", $time, name, exp, got));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s expected %h got %h", $time, name, exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    function automatic logic class_stall(input opcode_t op);
        logic stalled;
        if (fu_class_e'(op[OPCODE_W-1]) == FU_ARITH) begin
            stalled = o_stall_arith;
        end else begin
            stalled = o_stall_logic;
        end
        return stalled;
    endfunction

    task automatic load_patterns();
        int          fd;
        int          code;
        int          ctrl;
        string       word;
        logic [8*128-1:0] rest;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            abort_run("Cannot open the pattern file verif/issue_patterns.txt");
        end
        n_lines = 0;
        while ($fscanf(fd, "%s", word) == 1) begin
            if (word == "//") begin
                code = $fgets(rest, fd);
            end else begin
                if (n_lines == MAX_LINES) begin
                    abort_run("The pattern file has more lines than the table holds");
                end
                code = $sscanf(word, "%h", ctrl);
                code += $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                                line_op[n_lines], line_dst[n_lines],
                                line_tag_a[n_lines], line_tag_b[n_lines],
                                line_rdy_a[n_lines], line_rdy_b[n_lines],
                                line_data_a[n_lines], line_data_b[n_lines],
                                line_exp[n_lines]);
                if (code != 10) begin
                    abort_run($sformatf("Pattern line %0d is malformed", n_lines + 1));
                end
                line_ctrl[n_lines] = ctrl;
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic clear_scoreboard();
        for (int t = 0; t < N_TAGS; t++) begin
            pending[t] = 1'b0;
        end
        owed = 0;
    endtask

    task automatic record_dispatch();
        fu_class_e cls;
        tag_t      dst;
        cls = fu_class_e'(i_dispatch_opcode[OPCODE_W-1]);
        dst = i_dispatch_dst_tag;
        if (class_stall(i_dispatch_opcode)) begin
            abort_run("A dispatch was presented to a stalled station");
        end
        if (pending[dst]) begin
            abort_run($sformatf("Tag %h was dispatched again while still outstanding", dst));
        end
        pending[dst]    = 1'b1;
        exp_data[dst]   = cur_exp;
        tag_class[dst]  = cls;
        disp_seq[dst]   = n_dispatched;
        wait_tag_a[dst] = i_dispatch_src_tag_a;
        wait_tag_b[dst] = i_dispatch_src_tag_b;
        // A source that is on the CDB in the dispatch cycle is captured on the way in
        wait_a[dst]     = !i_dispatch_src_rdy_a
                          && !(o_cdb_valid === 1'b1 && o_cdb_tag == i_dispatch_src_tag_a);
        wait_b[dst]     = !i_dispatch_src_rdy_b
                          && !(o_cdb_valid === 1'b1 && o_cdb_tag == i_dispatch_src_tag_b);
        ready_at[dst]   = (wait_a[dst] || wait_b[dst]) ? NEVER_READY : edge_count;
        n_dispatched++;
        owed++;
    endtask

    // Waiting sources capture a tag in the edge where it is on the CDB
    task automatic wake_waiters(input tag_t t);
        for (int u = 0; u < N_TAGS; u++) begin
            if (pending[u] && (wait_a[u] || wait_b[u])) begin
                if (wait_tag_a[u] == t) begin
                    wait_a[u] = 1'b0;
                end
                if (wait_tag_b[u] == t) begin
                    wait_b[u] = 1'b0;
                end
                if (!wait_a[u] && !wait_b[u]) begin
                    ready_at[u] = edge_count;
                end
            end
        end
    endtask

    task automatic retire_result();
        tag_t t;
        t = o_cdb_tag;
        if (pending[t] !== 1'b1) begin
            abort_run($sformatf("The CDB carried tag %h which has no outstanding dispatch", t));
        end
        check_data("o_cdb_data", o_cdb_data, exp_data[t]);
        // Oldest ready entry issues first, so an older entry of the same station
        // that was ready no later than this one has already left
        for (int u = 0; u < N_TAGS; u++) begin
            if (pending[u] && u != t && tag_class[u] == tag_class[t]
                    && disp_seq[u] < disp_seq[t] && ready_at[u] <= ready_at[t]) begin
                check_tag("o_cdb_tag", t, tag_t'(u));
            end
        end
        pending[t] = 1'b0;
        owed--;
        wake_waiters(t);
    endtask

    // Monitor samples at the rising edge, before the edge updates any register
    always @(posedge clk) begin
        edge_count = edge_count + 1;
        if (after_clear && !i_rst) begin
            check_flag("o_cdb_valid", o_cdb_valid, 1'b0);
            check_flag("o_stall_arith", o_stall_arith, 1'b0);
            check_flag("o_stall_logic", o_stall_logic, 1'b0);
        end
        after_clear = i_rst || i_flush;
        if (!i_rst && o_cdb_valid === 1'b1) begin
            retire_result();
        end
        if (i_rst || i_flush) begin
            clear_scoreboard();
        end else if (i_dispatch_valid) begin
            record_dispatch();
        end
        owed_q <= owed;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles with results still missing",
                                cycle_count));
        end
    end

    // One dispatch, then one idle cycle, so the sampled stall is never stale
    task automatic dispatch_line(input int n);
        @(posedge clk);
        while (class_stall(line_op[n])) begin
            @(posedge clk);
        end
        i_dispatch_valid      <= 1'b1;
        i_dispatch_opcode     <= line_op[n];
        i_dispatch_dst_tag    <= line_dst[n];
        i_dispatch_src_tag_a  <= line_tag_a[n];
        i_dispatch_src_tag_b  <= line_tag_b[n];
        i_dispatch_src_rdy_a  <= line_rdy_a[n];
        i_dispatch_src_rdy_b  <= line_rdy_b[n];
        i_dispatch_src_data_a <= line_data_a[n];
        i_dispatch_src_data_b <= line_data_b[n];
        cur_exp               <= line_exp[n];
        @(posedge clk);
        i_dispatch_valid <= 1'b0;
    endtask

    task automatic wait_for_drain();
        @(posedge clk);
        while (owed_q != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic flush_pipeline();
        @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
    endtask

    task automatic run_line(input int n);
        case (line_ctrl[n])
            CTRL_DISPATCH, CTRL_ORDERED: dispatch_line(n);
            CTRL_DRAIN: wait_for_drain();
            CTRL_FLUSH: flush_pipeline();
            CTRL_STALL: begin
                @(posedge clk);
                if (fu_class_e'(line_op[n][OPCODE_W-1]) == FU_ARITH) begin
                    check_flag("o_stall_arith", o_stall_arith, line_exp[n][0]);
                end else begin
                    check_flag("o_stall_logic", o_stall_logic, line_exp[n][0]);
                end
            end
            default: abort_run($sformatf("Pattern line %0d has an unknown control word", n + 1));
        endcase
    endtask

    initial begin
        i_rst                 = 1'b1;
        i_flush               = 1'b0;
        i_dispatch_valid      = 1'b0;
        i_dispatch_opcode     = '0;
        i_dispatch_src_tag_a  = '0;
        i_dispatch_src_tag_b  = '0;
        i_dispatch_src_data_a = '0;
        i_dispatch_src_data_b = '0;
        i_dispatch_src_rdy_a  = 1'b0;
        i_dispatch_src_rdy_b  = 1'b0;
        i_dispatch_dst_tag    = '0;
        cur_exp               = '0;
        load_patterns();
        cycle_limit = CYCLES_PER_LINE * n_lines + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        i_rst <= 1'b0;
        for (int n = 0; n < n_lines; n++) begin
            run_line(n);
        end
        wait_for_drain();
        // A few quiet cycles catch any stray late result
        repeat (8) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/issue_patterns.txt */
// ctrl op dst tag_a tag_b rdy_a rdy_b data_a data_b expected, all hex
// ctrl 0 dispatch, 1 dispatch in order, 2 drain, 3 flush, 4 stall check with op as class
1 0 01 00 00 1 1 00000005 00000003 00000008
1 1 02 00 00 1 1 0000000a 00000003 00000007
0 8 03 00 00 1 1 0000ff0f 00f0f0ff 0000f00f
1 2 04 00 00 1 1 fffffffe 00000001 00000001
0 b 05 00 00 1 1 00000003 00000004 00000030
0 c 06 00 00 1 1 80000000 0000001f 00000001
0 9 09 07 08 0 0 00000000 00000000 0000ffff
0 a 08 07 00 0 1 00000000 0000ffff 0000edcb
0 0 07 00 00 1 1 00001000 00000234 00001234
2 0 00 00 00 0 0 00000000 00000000 00000000
0 0 0b 0a 00 0 1 00000000 00000001 12345679
0 1 0c 0a 00 0 1 00000000 00000002 12345676
0 2 0d 0a 0a 0 0 00000000 00000000 00000000
0 0 0e 0a 0a 0 0 00000000 00000000 2468acf0
4 0 00 00 00 0 0 00000000 00000000 00000001
4 8 00 00 00 0 0 00000000 00000000 00000000
0 9 0a 00 00 1 1 12340000 00005678 12345678
0 0 0f 00 00 1 1 00000001 00000002 00000003
2 0 00 00 00 0 0 00000000 00000000 00000000
0 0 10 11 00 0 1 00000000 00000001 00000000
0 8 12 11 00 0 1 00000000 00000001 00000000
0 0 13 00 00 1 1 00000001 00000001 00000002
3 0 00 00 00 0 0 00000000 00000000 00000000
0 1 11 00 00 1 1 00000009 00000004 00000005
0 9 15 00 00 1 1 000000f0 0000000f 000000ff

/* src.f */
hw/issue_pkg.sv
hw/issue_if.sv
hw/reservation_station.sv
hw/arith_unit.sv
hw/logic_unit.sv
hw/cdb_arbiter.sv
hw/issue_top.sv
verif/tb_clkgen.sv
verif/tb_issue.sv

/* Makefile */
SIM := obj_dir/Vtb_issue

.PHONY: all run clean

all: run

$(SIM): src.f $(shell grep -v '^+' src.f)
	verilator --binary --assert -Wno-fatal --top-module tb_issue -f src.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then \
		echo "Simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
